// ==== source/boxcar_avg.sv ====
// running boxcar average of one channel's magnitude
// one instance per antenna, updated on each valid beat
`default_nettype none

module boxcar_avg (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           s_axis_tvalid,
  input  wire [peak_pkg::mag_width-1:0] mag,
  output logic [peak_pkg::mag_width-1:0] avg
);

  // window history, index 0 newest
  logic [peak_pkg::mag_width-1:0] hist [0:(1 << peak_pkg::avg_power)-1];
  // sum of everything currently in the window
  logic [peak_pkg::sum_width-1:0] acc;

  //////////////////////////////
  // window update
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      acc <= '0;
      for (int i = 0; i < (1 << peak_pkg::avg_power); i++) begin
        hist[i] <= '0;
      end
    end else if (s_axis_tvalid) begin
      // add the new sample, drop the one leaving the window
      acc <= acc
             + {{peak_pkg::avg_power{1'b0}}, mag}
             - {{peak_pkg::avg_power{1'b0}}, hist[(1 << peak_pkg::avg_power)-1]};
      hist[0] <= mag;
      for (int i = 1; i < (1 << peak_pkg::avg_power); i++) begin
        hist[i] <= hist[i-1];
      end
    end
  end

  // divide by window size
  assign avg = acc[peak_pkg::sum_width-1:peak_pkg::avg_power];

  //////////////////////////////
  // checks
  //////////////////////////////

  // sum bounded by window times full-scale magnitude
  // catches a history/accumulator mismatch over many beats
  acc_bounded: assert property (
    @(posedge clk) disable iff (rst)
      acc <= {{peak_pkg::mag_width{1'b1}}, {peak_pkg::avg_power{1'b0}}}
  ) else $error("boxcar accumulator above window full scale");

endmodule

`default_nettype wire

// ==== source/burst_buffer.sv ====
// shift-register store of the most recent packed raw words
// written while idle and read out oldest first during a burst
`default_nettype none

module burst_buffer (
  input  wire                             clk,
  input  wire                             shift_en,
  input  wire  [peak_pkg::data_width-1:0] s_axis_tdata,
  output logic [peak_pkg::data_width-1:0] m_axis_tdata
);

  // entry 0 holds the newest word and the last entry the oldest
  logic [peak_pkg::data_width-1:0] mem [0:peak_pkg::burst_len-1];

  //////////////////////////////
  // shift chain
  //////////////////////////////

  // newest word enters at entry 0 on each shift
  always_ff @(posedge clk) begin
    if (shift_en) begin
      mem[0] <= s_axis_tdata;
      for (int i = 1; i < peak_pkg::burst_len; i++) begin
        mem[i] <= mem[i-1];
      end
    end
  end

  // oldest word drives the output and holds while shift_en is low
  assign m_axis_tdata = mem[peak_pkg::burst_len-1];

endmodule

`default_nettype wire

// ==== source/burst_ctrl.sv ====
// burst counter and output handshake for the capture buffer
// decides when the buffer shifts and drives valid and last downstream
`default_nettype none

module burst_ctrl (
  input  wire  clk,
  input  wire  rst,
  input  wire  s_axis_tvalid,
  input  wire  peak_rise,
  input  wire  m_axis_tready,
  output logic m_axis_tvalid,
  output logic m_axis_tlast,
  output logic shift_en
);

  // burst_len means idle, anything below is a readout position
  logic [peak_pkg::count_width-1:0] count;
  logic                             reading;
  // one output beat accepted downstream
  logic                             xfer;

  //////////////////////////////
  // state decode
  //////////////////////////////

  assign reading = (count < peak_pkg::burst_len);
  assign xfer    = m_axis_tvalid & m_axis_tready;

  //////////////////////////////
  // burst counter
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= peak_pkg::count_width'(peak_pkg::burst_len);
    end else if (!reading) begin
      // start of burst, readout begins next cycle
      if (peak_rise) begin
        count <= '0;
      end
    end else if (xfer) begin
      // peak_rise ignored here, only transfers advance
      count <= count + 1'b1;
    end
  end

  //////////////////////////////
  // outputs
  //////////////////////////////

  assign m_axis_tvalid = reading;
  assign m_axis_tlast  = (count == peak_pkg::count_width'(peak_pkg::burst_len - 1));

  // write while idle, read on each accepted output beat
  // input beats during readout are dropped from the buffer
  assign shift_en = (s_axis_tvalid & ~reading) | (xfer & reading);

  //////////////////////////////
  // checks
  //////////////////////////////

  last_has_valid: assert property (
    @(posedge clk) disable iff (rst)
      m_axis_tlast |-> m_axis_tvalid
  ) else $error("tlast without tvalid");

  // stream rule, valid may not drop before it is taken
  valid_held: assert property (
    @(posedge clk) disable iff (rst)
      m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid
  ) else $error("tvalid dropped under back-pressure");

  // buffer must not move while the consumer stalls
  no_stray_shift: assert property (
    @(posedge clk) disable iff (rst)
      reading && !xfer |-> !shift_en
  ) else $error("buffer shifted during readout without a transfer");

endmodule

`default_nettype wire

// ==== source/mag_delay_line.sv ====
// delays the packed magnitude word by half a burst of valid beats
// lines each sample up with the average of the window around it
`default_nettype none

module mag_delay_line (
  input  wire                               clk,
  input  wire                               rst,
  input  wire                               s_axis_tvalid,
  input  wire [peak_pkg::mag_bus_width-1:0] s_axis_tmag,
  output logic [peak_pkg::mag_bus_width-1:0] mag_delayed
);

  // stage 0 takes the newest beat
  logic [peak_pkg::mag_bus_width-1:0] stage [0:peak_pkg::mag_delay-1];

  //////////////////////////////
  // shift on valid beats only
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      // clear every stage
      for (int i = 0; i < peak_pkg::mag_delay; i++) begin
        stage[i] <= '0;
      end
    end else if (s_axis_tvalid) begin
      stage[0] <= s_axis_tmag;
      for (int i = 1; i < peak_pkg::mag_delay; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  // oldest stage is mag_delay valid beats back
  assign mag_delayed = stage[peak_pkg::mag_delay-1];

endmodule

`default_nettype wire

// ==== source/peak_detect_top.sv ====
// four-antenna peak detector top, raw and magnitude streams in
// emits a 32-beat burst of raw words around the first detected peak
`default_nettype none

module peak_detect_top (
  input  wire                                clk,
  input  wire                                rst,

  // input stream, always accepted
  input  wire                                s_axis_tvalid,
  input  wire  [peak_pkg::data_width-1:0]    s_axis_tdata,
  input  wire  [peak_pkg::mag_bus_width-1:0] s_axis_tmag,

  // burst output stream
  output logic                               m_axis_tvalid,
  input  wire                                m_axis_tready,
  output logic [peak_pkg::data_width-1:0]    m_axis_tdata,
  output logic                               m_axis_tlast
);

  // magnitude from half a burst back
  logic [peak_pkg::mag_bus_width-1:0] mag_delayed;
  // per-channel averages, packed like s_axis_tmag
  logic [peak_pkg::mag_bus_width-1:0] avg_bus;
  logic                               peak_rise;
  logic                               shift_en;

  //////////////////////////////
  // detection path
  //////////////////////////////

  mag_delay_line u_mag_delay_line (
    .clk           (clk),
    .rst           (rst),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tmag   (s_axis_tmag),
    .mag_delayed   (mag_delayed)
  );

  // one averager per antenna
  for (genvar c = 0; c < peak_pkg::num_channels; c++) begin : g_avg
    boxcar_avg u_boxcar_avg (
      .clk           (clk),
      .rst           (rst),
      .s_axis_tvalid (s_axis_tvalid),
      .mag           (s_axis_tmag[c*peak_pkg::mag_width +: peak_pkg::mag_width]),
      .avg           (avg_bus[c*peak_pkg::mag_width +: peak_pkg::mag_width])
    );
  end

  peak_threshold u_peak_threshold (
    .clk         (clk),
    .rst         (rst),
    .mag_delayed (mag_delayed),
    .avg_bus     (avg_bus),
    .peak_rise   (peak_rise)
  );

  //////////////////////////////
  // capture path
  //////////////////////////////

  burst_ctrl u_burst_ctrl (
    .clk           (clk),
    .rst           (rst),
    .s_axis_tvalid (s_axis_tvalid),
    .peak_rise     (peak_rise),
    .m_axis_tready (m_axis_tready),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tlast  (m_axis_tlast),
    .shift_en      (shift_en)
  );

  // buffer output is the stream data, no extra register
  burst_buffer u_burst_buffer (
    .clk          (clk),
    .shift_en     (shift_en),
    .s_axis_tdata (s_axis_tdata),
    .m_axis_tdata (m_axis_tdata)
  );

endmodule

`default_nettype wire

// ==== source/peak_pkg.sv ====
// shared sizing for the four-antenna peak detector
// every rtl block reads its widths and depths from here by scoped name
`default_nettype none

package peak_pkg;

  //////////////////////////////
  // channel layout
  //////////////////////////////

  // antenna channels
  localparam int num_channels = 4;
  // raw sample bits per channel
  localparam int chan_width = 32;
  // packed raw word, all channels
  localparam int data_width = chan_width * num_channels;
  // magnitude bits per channel
  localparam int mag_width = 16;
  // packed magnitude word
  localparam int mag_bus_width = mag_width * num_channels;

  //////////////////////////////
  // burst capture
  //////////////////////////////

  // beats per burst, also buffer depth
  localparam int burst_len = 32;
  // must hold burst_len itself (idle value)
  localparam int count_width = 6;
  // half a burst, centres the burst on its peak
  localparam int mag_delay = burst_len / 2;

  //////////////////////////////
  // detection math
  //////////////////////////////

  // boxcar window is 2**avg_power samples
  localparam int avg_power = 5;
  localparam int sum_width = mag_width + avg_power;
  // peak multiplier is 2**thresh_shift
  localparam int thresh_shift = 3;
  localparam int thresh_width = mag_width + thresh_shift;

endpackage

`default_nettype wire

// ==== source/peak_threshold.sv ====
// per-channel threshold and strict compare against the delayed magnitude
// emits one pulse when any channel first rises above its threshold
`default_nettype none

module peak_threshold (
  input  wire                               clk,
  input  wire                               rst,
  input  wire [peak_pkg::mag_bus_width-1:0] mag_delayed,
  input  wire [peak_pkg::mag_bus_width-1:0] avg_bus,
  output logic                              peak_rise
);

  // one registered threshold per channel
  logic [peak_pkg::thresh_width-1:0] thresh [0:peak_pkg::num_channels-1];
  // registered compare results
  logic [peak_pkg::num_channels-1:0] peak_flag;
  // any channel above threshold and its copy one cycle back
  logic                              peak_any;
  logic                              peak_any_d;

  //////////////////////////////
  // threshold stage
  //////////////////////////////

  // (avg + 1) * 8 recomputed every cycle from avg
  always_ff @(posedge clk) begin
    for (int c = 0; c < peak_pkg::num_channels; c++) begin
      // saturate where a full-scale avg would wrap to zero
      // no magnitude can exceed an all-ones threshold anyway
      if (&avg_bus[c*peak_pkg::mag_width +: peak_pkg::mag_width]) begin
        thresh[c] <= '1;
      end else begin
        thresh[c] <= ({{peak_pkg::thresh_shift{1'b0}},
                       avg_bus[c*peak_pkg::mag_width +: peak_pkg::mag_width]} + 1'b1)
                     << peak_pkg::thresh_shift;
      end
    end
  end

  //////////////////////////////
  // compare and edge detect
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      peak_flag  <= '0;
      peak_any_d <= 1'b0;
    end else begin
      // strictly greater so a sample equal to threshold is no peak
      for (int c = 0; c < peak_pkg::num_channels; c++) begin
        peak_flag[c] <= mag_delayed[c*peak_pkg::mag_width +: peak_pkg::mag_width]
                        > thresh[c];
      end
      peak_any_d <= peak_any;
    end
  end

  assign peak_any = |peak_flag;

  // wide peaks give a single pulse on the leading edge
  assign peak_rise = peak_any & ~peak_any_d;

endmodule

`default_nettype wire

// ==== verification/peak_detect_tb.sv ====
// directed testbench for the four-antenna peak detector
// drives an indexed input stream and checks each captured burst against the sent record
`default_nettype none

module peak_detect_tb;

  logic                               clk;
  logic                               rst;
  logic                               s_axis_tvalid;
  logic [peak_pkg::data_width-1:0]    s_axis_tdata;
  logic [peak_pkg::mag_bus_width-1:0] s_axis_tmag;
  logic                               m_axis_tvalid;
  logic                               m_axis_tready;
  logic [peak_pkg::data_width-1:0]    m_axis_tdata;
  logic                               m_axis_tlast;

  // stimulus and scoreboard state
  int                              beat_idx;
  int                              errors;
  int                              tests_run;
  int                              tests_ok;
  integer                          seed;
  bit                              random_ready;
  bit                              valid_seen;
  // last sample was valid with ready low
  bit                              stalled;
  logic [peak_pkg::data_width-1:0] held_data;
  logic                            held_last;
  // every word sent indexed by beat
  logic [peak_pkg::data_width-1:0] sent_q[$];
  // accepted output beats
  logic [peak_pkg::data_width-1:0] burst_q[$];
  logic                            last_q[$];

  peak_detect_top UUT (
    .clk           (clk),
    .rst           (rst),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tmag   (s_axis_tmag),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////
  // compare tasks
  //////////////////////////////

  task automatic check_word(input logic [peak_pkg::data_width-1:0] got,
                            input logic [peak_pkg::data_width-1:0] exp,
                            input string msg);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string msg);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s, got %b expected %b", $time, msg, got, exp);
      errors++;
    end
  endtask

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////

  // same magnitude on every channel
  function automatic logic [peak_pkg::mag_bus_width-1:0] flat_mag(input int level);
    logic [peak_pkg::mag_width-1:0] lv;
    lv = level[peak_pkg::mag_width-1:0];
    return {peak_pkg::num_channels{lv}};
  endfunction

  function automatic logic [peak_pkg::mag_bus_width-1:0] set_chan(
    input logic [peak_pkg::mag_bus_width-1:0] bus, input int ch, input int value);
    logic [peak_pkg::mag_bus_width-1:0] r;
    r = bus;
    r[ch*peak_pkg::mag_width +: peak_pkg::mag_width] = value[peak_pkg::mag_width-1:0];
    return r;
  endfunction

  task automatic apply_reset();
    rst           <= 1'b1;
    s_axis_tvalid <= 1'b0;
    repeat (3) @(posedge clk);
    rst     <= 1'b0;
    stalled  = 1'b0;
  endtask

  // one clock that observes the outputs and then drives the next beat
  task automatic step_beat(input logic [peak_pkg::mag_bus_width-1:0] mag);
    logic [peak_pkg::chan_width-1:0] idx;
    int                              r;
    @(posedge clk);
    if (m_axis_tvalid && m_axis_tready) begin
      burst_q.push_back(m_axis_tdata);
      last_q.push_back(m_axis_tlast);
    end
    // stalled beat must be offered again unchanged
    if (stalled) begin
      check_bit(m_axis_tvalid, 1'b1, "tvalid held under back-pressure");
      check_word(m_axis_tdata, held_data, "tdata held under back-pressure");
      check_bit(m_axis_tlast, held_last, "tlast held under back-pressure");
    end
    stalled    = m_axis_tvalid && !m_axis_tready;
    held_data  = m_axis_tdata;
    held_last  = m_axis_tlast;
    valid_seen = valid_seen | m_axis_tvalid;
    // beat index repeated in every channel
    idx = beat_idx[peak_pkg::chan_width-1:0];
    s_axis_tvalid <= 1'b1;
    s_axis_tdata  <= {peak_pkg::num_channels{idx}};
    s_axis_tmag   <= mag;
    sent_q.push_back({peak_pkg::num_channels{idx}});
    beat_idx++;
    r = $random(seed);
    m_axis_tready <= random_ready ? r[0] : 1'b1;
  endtask

  task automatic run_flat(input logic [peak_pkg::mag_bus_width-1:0] mag, input int beats);
    for (int i = 0; i < beats; i++) begin
      step_beat(mag);
    end
  endtask

  // peak of given height and width on one channel over a base level
  task automatic inject_peak(input logic [peak_pkg::mag_bus_width-1:0] base,
                             input int chan, input int height, input int width,
                             output int peak_idx);
    peak_idx = beat_idx;
    for (int i = 0; i < width; i++) begin
      step_beat(set_chan(base, chan, height));
    end
  endtask

  //////////////////////////////
  // burst capture and check
  //////////////////////////////

  task automatic collect_burst(input logic [peak_pkg::mag_bus_width-1:0] mag,
                               input int wait_limit, input int drain_limit);
    int n;
    n = 0;
    while (!m_axis_tvalid && n < wait_limit) begin
      step_beat(mag);
      n++;
    end
    if (!m_axis_tvalid) begin
      $display("[%0t] timeout: no burst started within %0d beats", $time, wait_limit);
      errors++;
      return;
    end
    n = 0;
    while (!(last_q.size() > 0 && last_q[$]) && n < drain_limit) begin
      step_beat(mag);
      n++;
    end
    if (!(last_q.size() > 0 && last_q[$])) begin
      $display("[%0t] timeout: burst did not end within %0d beats", $time, drain_limit);
      errors++;
    end
  endtask

  // burst must be burst_len consecutive sent words holding the peak beat
  task automatic check_burst(input int peak_idx);
    int first;
    bit in_burst;
    if (burst_q.size() != peak_pkg::burst_len) begin
      $display("[%0t] burst length wrong: %0d beats received instead of %0d",
               $time, burst_q.size(), peak_pkg::burst_len);
      errors++;
      return;
    end
    first = int'(burst_q[0][peak_pkg::chan_width-1:0]);
    if (first + peak_pkg::burst_len > sent_q.size()) begin
      $display("[%0t] burst starts at beat %0d, which was never sent in full", $time, first);
      errors++;
      return;
    end
    for (int k = 0; k < peak_pkg::burst_len; k++) begin
      check_word(burst_q[k], sent_q[first + k], $sformatf("burst beat %0d", k));
      check_bit(last_q[k], k == peak_pkg::burst_len - 1, $sformatf("tlast on beat %0d", k));
    end
    in_burst = (peak_idx >= first) && (peak_idx < first + peak_pkg::burst_len);
    check_bit(in_burst, 1'b1, "peak beat inside burst");
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      tests_ok++;
      $display("[%0t] %s: ok", $time, name);
    end else begin
      $display("[%0t] %s: FAIL, %0d wrong", $time, name, errors - err_before);
    end
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic test_quiet();
    int err_before;
    err_before = errors;
    apply_reset();
    valid_seen = 1'b0;
    run_flat(flat_mag(100), 200);
    check_bit(valid_seen, 1'b0, "tvalid on quiet input");
    finish_test("test 1 reset and quiet input", err_before);
  endtask

  // the centred window holds the peak itself so the base level stays small
  task automatic test_single_peak(input bit with_backpressure, input string name);
    int                                 err_before;
    int                                 peak_idx;
    logic [peak_pkg::mag_bus_width-1:0] base;
    err_before   = errors;
    base         = flat_mag(3);
    random_ready = with_backpressure;
    // fill window and buffer
    run_flat(base, 80);
    burst_q.delete();
    last_q.delete();
    inject_peak(base, 0, (3 + 1) * (1 << peak_pkg::thresh_shift) + 1, 1, peak_idx);
    collect_burst(base, 100, with_backpressure ? 600 : 100);
    check_burst(peak_idx);
    random_ready = 1'b0;
    finish_test(name, err_before);
  endtask

  // three beats of 9 over a zero base are the widest flat run above (avg+1)*8
  task automatic test_wide_peak();
    int                                 err_before;
    int                                 peak_idx;
    logic [peak_pkg::mag_bus_width-1:0] base;
    err_before = errors;
    base       = set_chan(flat_mag(3), 3, 0);
    run_flat(base, 80);
    burst_q.delete();
    last_q.delete();
    inject_peak(base, 3, 9, 3, peak_idx);
    collect_burst(base, 100, 100);
    check_burst(peak_idx);
    valid_seen = 1'b0;
    run_flat(base, 100);
    check_bit(valid_seen, 1'b0, "second burst after wide peak");
    finish_test("test 3 wide peak channel 3", err_before);
  endtask

  task automatic test_exact_threshold();
    int                                 err_before;
    int                                 peak_idx;
    logic [peak_pkg::mag_bus_width-1:0] base;
    err_before = errors;
    base       = flat_mag(3);
    run_flat(base, 80);
    valid_seen = 1'b0;
    // equal to threshold and rejected by the strict compare
    inject_peak(base, 0, (3 + 1) * (1 << peak_pkg::thresh_shift), 1, peak_idx);
    run_flat(base, 100);
    check_bit(valid_seen, 1'b0, "burst on peak equal to threshold");
    finish_test("test 4 exact threshold", err_before);
  endtask

  initial begin
    rst           = 1'b1;
    s_axis_tvalid = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tmag   = '0;
    m_axis_tready = 1'b1;
    seed          = 32'hef9;
    beat_idx      = 0;
    errors        = 0;
    tests_run     = 0;
    tests_ok      = 0;
    random_ready  = 1'b0;
    valid_seen    = 1'b0;
    stalled       = 1'b0;
    held_data     = '0;
    held_last     = 1'b0;
    test_quiet();
    test_single_peak(1'b0, "test 2 single peak channel 0");
    test_wide_peak();
    test_exact_threshold();
    test_single_peak(1'b1, "test 5 back-pressure");
    $display("%0d of %0d tests ok, %0d checks wrong", tests_ok, tests_run, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/peak_pkg.sv
source/mag_delay_line.sv
source/boxcar_avg.sv
source/peak_threshold.sv
source/burst_ctrl.sv
source/burst_buffer.sv
source/peak_detect_top.sv
verification/peak_detect_tb.sv
